// ==== cache_dma_pkg.sv ====
// cache side is fixed at 32-bit words, 8-word blocks and 28-bit byte addresses, with 16 bits per bank
`default_nettype none

package cache_dma_pkg;

  localparam int cache_word_width = 32;
  localparam int block_words = 8;
  localparam int cache_addr_width = 28; // byte address
  localparam int bank_addr_width = 16;  // bits a single bank really uses

  // dma packet opcode
  typedef enum logic {
    DMA_READ  = 1'b0,
    DMA_WRITE = 1'b1
  } dma_op_e;

  // one block transfer request from a cache
  typedef struct packed {
    dma_op_e                     op;
    logic [cache_addr_width-1:0] addr;
    logic [block_words-1:0]      mask; // one bit per block word
  } dma_pkt_s;

endpackage

`default_nettype wire

// ==== dram_chan_pkg.sv ====
// dram channel has 64-bit beats and 24-bit byte addresses, so a 32-byte block takes four beats
`default_nettype none

package dram_chan_pkg;

  localparam int dram_data_width = 64;
  localparam int dram_addr_width = 24;
  localparam int words_per_beat = 2;
  localparam int beats_per_block = 4;

  typedef enum logic {
    DRAM_READ  = 1'b0,
    DRAM_WRITE = 1'b1
  } dram_op_e;

  typedef struct packed {
    dram_op_e                   op;
    logic [dram_addr_width-1:0] addr;
  } dram_req_s;

  typedef struct packed {
    logic [dram_data_width-1:0]   data;
    logic [dram_data_width/8-1:0] mask; // byte enables
  } dram_wdata_s;

  // read beat comes back with its own address
  typedef struct packed {
    logic [dram_data_width-1:0] data;
    logic [dram_addr_width-1:0] addr;
  } dram_rdata_s;

endpackage

`default_nettype wire

// ==== dma_req_arbiter.sv ====
// grant is combinational from the valid inputs, and grant_yumi_i must only be raised with grant_v_o
`timescale 1ns/1ps
`default_nettype none

module dma_req_arbiter #(
  parameter int num_cache_p = 4,
  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  logic                                     core_clk_i,
  input  logic                                     core_reset_i,
  input  cache_dma_pkg::dma_pkt_s [num_cache_p-1:0] dma_pkt_i,
  input  logic [num_cache_p-1:0]                   dma_pkt_v_i,
  output logic [num_cache_p-1:0]                   dma_pkt_yumi_o,
  output cache_dma_pkg::dma_pkt_s                  grant_pkt_o,
  output logic [idx_width_lp-1:0]                  grant_idx_o,
  output logic                                     grant_v_o,
  input  logic                                     grant_yumi_i
);

  logic [idx_width_lp-1:0] ptr_r; // cache with top priority
  logic                    accept;

  // first valid cache at or after the pointer
  always_comb begin
    int cand;
    grant_v_o = 1'b0;
    grant_idx_o = '0;
    for (int i = 0; i < num_cache_p; i++) begin
      cand = (int'(ptr_r) + i) % num_cache_p;
      if (!grant_v_o && dma_pkt_v_i[cand]) begin
        grant_v_o = 1'b1;
        grant_idx_o = idx_width_lp'(cand);
      end
    end
  end

  assign grant_pkt_o = dma_pkt_i[grant_idx_o];
  assign accept = grant_v_o && grant_yumi_i;

  always_comb begin
    dma_pkt_yumi_o = '0;
    dma_pkt_yumi_o[grant_idx_o] = accept; // only the winner sees yumi
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      ptr_r <= '0;
    end else if (accept) begin
      // one past the winner
      if (grant_idx_o == idx_width_lp'(num_cache_p - 1)) begin
        ptr_r <= '0;
      end else begin
        ptr_r <= grant_idx_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dram_req_splitter.sv ====
// one block at a time, four requests per block; wcmd_v_o is only raised while wcmd_ready_i is high
`timescale 1ns/1ps
`default_nettype none

module dram_req_splitter #(
  parameter int num_cache_p = 4,
  parameter int req_queue_depth_p = 16,
  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  logic                                      core_clk_i,
  input  logic                                      core_reset_i,
  input  cache_dma_pkg::dma_pkt_s                   grant_pkt_i,
  input  logic [idx_width_lp-1:0]                   grant_idx_i,
  input  logic                                      grant_v_i,
  output logic                                      grant_yumi_o,
  output logic                                      wcmd_v_o,
  output logic [idx_width_lp-1:0]                   wcmd_idx_o,
  output logic [dram_chan_pkg::words_per_beat-1:0]  wcmd_mask_o,
  input  logic                                      wcmd_ready_i,
  output dram_chan_pkg::dram_req_s                  dram_req_o,
  output logic                                      dram_req_v_o,
  input  logic                                      dram_req_yumi_i
);

  import cache_dma_pkg::*;
  import dram_chan_pkg::*;

  localparam int beat_bits_lp = $clog2(beats_per_block);
  localparam int byte_off_lp = $clog2(dram_data_width / 8);
  localparam int block_off_lp = beat_bits_lp + byte_off_lp;
  localparam int pad_width_lp = dram_addr_width - bank_addr_width - idx_width_lp;
  localparam int qptr_width_lp = $clog2(req_queue_depth_p);
  localparam int qcnt_width_lp = qptr_width_lp + 1;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_BURST
  } split_state_e;

  split_state_e            state_r;
  logic [beat_bits_lp-1:0] beat_r;
  dma_pkt_s                pkt_r;
  logic [idx_width_lp-1:0] idx_r;

  dma_pkt_s                cur_pkt;
  logic [idx_width_lp-1:0] cur_idx;
  logic [beat_bits_lp-1:0] cur_beat;
  logic                    cur_wr;
  logic                    can_issue;
  logic                    issue;
  logic                    last_beat;
  dram_req_s               new_req;

  dram_req_s                q_mem [req_queue_depth_p];
  logic [qptr_width_lp-1:0] q_wr_r;
  logic [qptr_width_lp-1:0] q_rd_r;
  logic [qcnt_width_lp-1:0] q_cnt_r;
  logic                     q_full;
  logic                     q_pop;

  function automatic logic [qptr_width_lp-1:0] q_next(input logic [qptr_width_lp-1:0] p);
    return (p == qptr_width_lp'(req_queue_depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  // beat 0 comes straight from the arbiter, later beats from the captured packet
  always_comb begin
    if (state_r == SPLIT_IDLE) begin
      cur_pkt = grant_pkt_i;
      cur_idx = grant_idx_i;
      cur_beat = '0;
    end else begin
      cur_pkt = pkt_r;
      cur_idx = idx_r;
      cur_beat = beat_r;
    end
  end

  assign cur_wr = (cur_pkt.op == DMA_WRITE);
  assign can_issue = !q_full && (!cur_wr || wcmd_ready_i); // writes also need packer room
  assign issue = can_issue && ((state_r == SPLIT_BURST) || grant_v_i);
  assign grant_yumi_o = (state_r == SPLIT_IDLE) && grant_v_i && can_issue;
  assign last_beat = (cur_beat == beat_bits_lp'(beats_per_block - 1));

  assign wcmd_v_o = issue && cur_wr;
  assign wcmd_idx_o = cur_idx;
  // reads keep a full mask
  assign wcmd_mask_o = cur_wr ? cur_pkt.mask[cur_beat*words_per_beat +: words_per_beat] : '1;

  // cache index on top, then pad, block address, beat index, byte offset
  always_comb begin
    new_req.op = cur_wr ? DRAM_WRITE : DRAM_READ;
    new_req.addr = {cur_idx,
                    {pad_width_lp{1'b0}},
                    cur_pkt.addr[bank_addr_width-1:block_off_lp],
                    cur_beat,
                    {byte_off_lp{1'b0}}};
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      state_r <= SPLIT_IDLE;
      beat_r <= '0;
    end else if (issue) begin
      state_r <= last_beat ? SPLIT_IDLE : SPLIT_BURST;
      beat_r <= last_beat ? '0 : cur_beat + 1'b1;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (grant_yumi_o) begin
      pkt_r <= grant_pkt_i;
      idx_r <= grant_idx_i;
    end
  end

  // request queue
  assign q_full = (q_cnt_r == qcnt_width_lp'(req_queue_depth_p));
  assign q_pop = dram_req_v_o && dram_req_yumi_i;

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      q_wr_r <= '0;
      q_rd_r <= '0;
      q_cnt_r <= '0;
    end else begin
      if (issue) begin
        q_wr_r <= q_next(q_wr_r);
      end
      if (q_pop) begin
        q_rd_r <= q_next(q_rd_r);
      end
      q_cnt_r <= q_cnt_r + qcnt_width_lp'(issue) - qcnt_width_lp'(q_pop);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (issue) begin
      q_mem[q_wr_r] <= new_req;
    end
  end

  assign dram_req_o = q_mem[q_rd_r];
  assign dram_req_v_o = (q_cnt_r != '0); // earliest one cycle after enqueue

endmodule

`default_nettype wire

// ==== dram_write_packer.sv ====
// each cache must send its write words in block order; one beat is collected while none is held
`timescale 1ns/1ps
`default_nettype none

module dram_write_packer #(
  parameter int num_cache_p = 4,
  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  logic                                                    core_clk_i,
  input  logic                                                    core_reset_i,
  input  logic                                                    wcmd_v_i,
  input  logic [idx_width_lp-1:0]                                 wcmd_idx_i,
  input  logic [dram_chan_pkg::words_per_beat-1:0]                wcmd_mask_i,
  output logic                                                    wcmd_ready_o,
  input  logic [num_cache_p-1:0][cache_dma_pkg::cache_word_width-1:0] dma_data_i,
  input  logic [num_cache_p-1:0]                                  dma_data_v_i,
  output logic [num_cache_p-1:0]                                  dma_data_yumi_o,
  output dram_chan_pkg::dram_wdata_s                              dram_wdata_o,
  output logic                                                    dram_wdata_v_o,
  input  logic                                                    dram_wdata_yumi_i
);

  import cache_dma_pkg::*;
  import dram_chan_pkg::*;

  localparam int cq_depth_lp = 4;
  localparam int cq_ptr_width_lp = $clog2(cq_depth_lp);
  localparam int bytes_per_word_lp = cache_word_width / 8;
  localparam int wsel_width_lp = $clog2(words_per_beat);

  typedef struct packed {
    logic [idx_width_lp-1:0]   idx;
    logic [words_per_beat-1:0] mask;
  } wcmd_s;

  wcmd_s                      cq_mem [cq_depth_lp];
  logic [cq_ptr_width_lp-1:0] cq_wr_r;
  logic [cq_ptr_width_lp-1:0] cq_rd_r;
  logic [cq_ptr_width_lp:0]   cq_cnt_r;
  logic                       cq_push;
  logic                       cq_pop;
  wcmd_s                      head;

  logic [wsel_width_lp-1:0]   word_r;   // next word slot within the beat
  logic                       hold_v_r; // finished beat waiting for yumi
  dram_wdata_s                beat_r;
  logic                       take;
  logic [dram_data_width/8-1:0] byte_mask;

  // command queue
  assign wcmd_ready_o = (cq_cnt_r != (cq_ptr_width_lp + 1)'(cq_depth_lp));
  assign cq_push = wcmd_v_i && wcmd_ready_o;
  assign head = cq_mem[cq_rd_r];

  always_ff @(posedge core_clk_i) begin
    if (cq_push) begin
      cq_mem[cq_wr_r] <= '{idx: wcmd_idx_i, mask: wcmd_mask_i};
    end
  end

  // word collector
  assign take = (cq_cnt_r != '0) && !hold_v_r && dma_data_v_i[head.idx];
  assign cq_pop = take && (word_r == wsel_width_lp'(words_per_beat - 1));

  always_comb begin
    dma_data_yumi_o = '0;
    dma_data_yumi_o[head.idx] = take;
  end

  // word mask bit spread over that word's bytes
  always_comb begin
    for (int w = 0; w < words_per_beat; w++) begin
      byte_mask[w*bytes_per_word_lp +: bytes_per_word_lp] = {bytes_per_word_lp{head.mask[w]}};
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (take) begin
      beat_r.data[word_r*cache_word_width +: cache_word_width] <= dma_data_i[head.idx];
      beat_r.mask <= byte_mask;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      cq_wr_r <= '0;
      cq_rd_r <= '0;
      cq_cnt_r <= '0;
      word_r <= '0;
      hold_v_r <= 1'b0;
    end else begin
      if (cq_push) begin
        cq_wr_r <= cq_wr_r + 1'b1;
      end
      if (cq_pop) begin
        cq_rd_r <= cq_rd_r + 1'b1;
      end
      cq_cnt_r <= cq_cnt_r + (cq_ptr_width_lp + 1)'(cq_push) - (cq_ptr_width_lp + 1)'(cq_pop);
      if (take) begin
        word_r <= cq_pop ? '0 : word_r + 1'b1;
      end
      if (cq_pop) begin
        hold_v_r <= 1'b1;
      end else if (dram_wdata_yumi_i) begin
        hold_v_r <= 1'b0;
      end
    end
  end

  assign dram_wdata_o = beat_r;
  assign dram_wdata_v_o = hold_v_r;

endmodule

`default_nettype wire

// ==== dram_read_router.sv ====
// no credit control; a beat that finds its cache queue too full to hold both words is dropped
`timescale 1ns/1ps
`default_nettype none

module dram_read_router #(
  parameter int num_cache_p = 4,
  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1
) (
  input  logic                                                        core_clk_i,
  input  logic                                                        core_reset_i,
  input  dram_chan_pkg::dram_rdata_s                                  dram_rdata_i,
  input  logic                                                        dram_rdata_v_i,
  output logic [num_cache_p-1:0][cache_dma_pkg::cache_word_width-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                                      dma_data_v_o,
  input  logic [num_cache_p-1:0]                                      dma_data_ready_i
);

  import cache_dma_pkg::*;
  import dram_chan_pkg::*;

  localparam int rq_depth_lp = 2 * block_words; // two blocks per cache
  localparam int rq_ptr_width_lp = $clog2(rq_depth_lp);
  localparam int rq_cnt_width_lp = rq_ptr_width_lp + 1;

  logic [idx_width_lp-1:0] beat_idx;

  assign beat_idx = dram_rdata_i.addr[dram_addr_width-1 -: idx_width_lp]; // owner from top bits

  for (genvar c = 0; c < num_cache_p; c++) begin : g_queue
    logic [cache_word_width-1:0] mem_r [rq_depth_lp];
    logic [rq_ptr_width_lp-1:0]  wr_ptr_r;
    logic [rq_ptr_width_lp-1:0]  rd_ptr_r;
    logic [rq_cnt_width_lp-1:0]  cnt_r;
    logic                        push;
    logic                        pop;

    assign push = dram_rdata_v_i && (beat_idx == idx_width_lp'(c))
                  && (cnt_r <= rq_cnt_width_lp'(rq_depth_lp - words_per_beat));
    assign pop = dma_data_v_o[c] && dma_data_ready_i[c];

    // low word goes in first
    always_ff @(posedge core_clk_i) begin
      if (push) begin
        for (int w = 0; w < words_per_beat; w++) begin
          mem_r[wr_ptr_r + rq_ptr_width_lp'(w)] <=
            dram_rdata_i.data[w*cache_word_width +: cache_word_width];
        end
      end
    end

    always_ff @(posedge core_clk_i) begin
      if (core_reset_i) begin
        wr_ptr_r <= '0;
        rd_ptr_r <= '0;
        cnt_r <= '0;
      end else begin
        if (push) begin
          wr_ptr_r <= wr_ptr_r + rq_ptr_width_lp'(words_per_beat);
        end
        if (pop) begin
          rd_ptr_r <= rd_ptr_r + 1'b1;
        end
        cnt_r <= cnt_r + (push ? rq_cnt_width_lp'(words_per_beat) : '0)
                 - rq_cnt_width_lp'(pop);
      end
    end

    assign dma_data_o[c] = mem_r[rd_ptr_r];
    assign dma_data_v_o[c] = (cnt_r != '0); // one cycle after the dram beat
  end

endmodule

`default_nettype wire

// ==== cache_to_dram_top.sv ====
// single clock domain; read data has no flow control, so caches must keep dma_data_ready_i mostly high
`timescale 1ns/1ps
`default_nettype none

module cache_to_dram_top #(
  parameter int num_cache_p = 4,      // 1 to 8 caches
  parameter int req_queue_depth_p = 16
) (
  input  logic                                                        core_clk_i,
  input  logic                                                        core_reset_i,
  // cache side
  input  cache_dma_pkg::dma_pkt_s [num_cache_p-1:0]                   dma_pkt_i,
  input  logic [num_cache_p-1:0]                                      dma_pkt_v_i,
  output logic [num_cache_p-1:0]                                      dma_pkt_yumi_o,
  output logic [num_cache_p-1:0][cache_dma_pkg::cache_word_width-1:0] dma_data_o,
  output logic [num_cache_p-1:0]                                      dma_data_v_o,
  input  logic [num_cache_p-1:0]                                      dma_data_ready_i,
  input  logic [num_cache_p-1:0][cache_dma_pkg::cache_word_width-1:0] dma_data_i,
  input  logic [num_cache_p-1:0]                                      dma_data_v_i,
  output logic [num_cache_p-1:0]                                      dma_data_yumi_o,
  // dram side
  output dram_chan_pkg::dram_req_s                                    dram_req_o,
  output logic                                                        dram_req_v_o,
  input  logic                                                        dram_req_yumi_i,
  output dram_chan_pkg::dram_wdata_s                                  dram_wdata_o,
  output logic                                                        dram_wdata_v_o,
  input  logic                                                        dram_wdata_yumi_i,
  input  dram_chan_pkg::dram_rdata_s                                  dram_rdata_i,
  input  logic                                                        dram_rdata_v_i
);

  import cache_dma_pkg::*;
  import dram_chan_pkg::*;

  localparam int idx_width_lp = (num_cache_p > 1) ? $clog2(num_cache_p) : 1;

  dma_pkt_s                  grant_pkt;
  logic [idx_width_lp-1:0]   grant_idx;
  logic                      grant_v;
  logic                      grant_yumi;

  logic                      wcmd_v;
  logic [idx_width_lp-1:0]   wcmd_idx;
  logic [words_per_beat-1:0] wcmd_mask;
  logic                      wcmd_ready;

  dma_req_arbiter #(.num_cache_p(num_cache_p)) arb_i (
    .core_clk_i     (core_clk_i),
    .core_reset_i   (core_reset_i),
    .dma_pkt_i      (dma_pkt_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_o (dma_pkt_yumi_o),
    .grant_pkt_o    (grant_pkt),
    .grant_idx_o    (grant_idx),
    .grant_v_o      (grant_v),
    .grant_yumi_i   (grant_yumi)
  );

  dram_req_splitter #(
    .num_cache_p       (num_cache_p),
    .req_queue_depth_p (req_queue_depth_p)
  ) split_i (
    .core_clk_i      (core_clk_i),
    .core_reset_i    (core_reset_i),
    .grant_pkt_i     (grant_pkt),
    .grant_idx_i     (grant_idx),
    .grant_v_i       (grant_v),
    .grant_yumi_o    (grant_yumi),
    .wcmd_v_o        (wcmd_v),
    .wcmd_idx_o      (wcmd_idx),
    .wcmd_mask_o     (wcmd_mask),
    .wcmd_ready_i    (wcmd_ready),
    .dram_req_o      (dram_req_o),
    .dram_req_v_o    (dram_req_v_o),
    .dram_req_yumi_i (dram_req_yumi_i)
  );

  dram_write_packer #(.num_cache_p(num_cache_p)) pack_i (
    .core_clk_i        (core_clk_i),
    .core_reset_i      (core_reset_i),
    .wcmd_v_i          (wcmd_v),
    .wcmd_idx_i        (wcmd_idx),
    .wcmd_mask_i       (wcmd_mask),
    .wcmd_ready_o      (wcmd_ready),
    .dma_data_i        (dma_data_i),
    .dma_data_v_i      (dma_data_v_i),
    .dma_data_yumi_o   (dma_data_yumi_o),
    .dram_wdata_o      (dram_wdata_o),
    .dram_wdata_v_o    (dram_wdata_v_o),
    .dram_wdata_yumi_i (dram_wdata_yumi_i)
  );

  dram_read_router #(.num_cache_p(num_cache_p)) route_i (
    .core_clk_i       (core_clk_i),
    .core_reset_i     (core_reset_i),
    .dram_rdata_i     (dram_rdata_i),
    .dram_rdata_v_i   (dram_rdata_v_i),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_cache_to_dram.sv ====
// 4 caches; read-ready lows stay at most 4 cycles since the read path has no credits
`timescale 1ns/1ps
`default_nettype none

module tb_cache_to_dram;

  import cache_dma_pkg::*;
  import dram_chan_pkg::*;

  localparam int num_cache = 4;
  localparam int idx_w = $clog2(num_cache);
  localparam int pkts_per_cache = 12;
  localparam int wait_limit = 40000; // cycles per wait loop

  logic                                       core_clk;
  logic                                       core_reset;
  dma_pkt_s [num_cache-1:0]                   dma_pkt = '0;
  logic [num_cache-1:0]                       dma_pkt_v = '0;
  logic [num_cache-1:0]                       dma_pkt_yumi;
  logic [num_cache-1:0][cache_word_width-1:0] rd_data;
  logic [num_cache-1:0]                       rd_v;
  logic [num_cache-1:0]                       rd_ready = '0;
  logic [num_cache-1:0][cache_word_width-1:0] wr_data = '0;
  logic [num_cache-1:0]                       wr_v = '0;
  logic [num_cache-1:0]                       wr_yumi;
  dram_req_s                                  dram_req;
  logic                                       dram_req_v;
  logic                                       dram_req_yumi = 1'b0;
  dram_wdata_s                                dram_wdata;
  logic                                       dram_wdata_v;
  logic                                       dram_wdata_yumi = 1'b0;
  dram_rdata_s                                dram_rdata = '0;
  logic                                       dram_rdata_v = 1'b0;

  integer                      seed;
  logic                        run = 1'b0;
  dma_pkt_s                    pkt_q [num_cache][$];
  logic [cache_word_width-1:0] word_q [num_cache][$];   // write words each cache will offer
  dram_req_s                   exp_req [num_cache][$];
  dram_wdata_s                 exp_wdata [num_cache][$];
  logic [cache_word_width-1:0] exp_rd [num_cache][$];
  dram_req_s                   pend_q [$];   // accepted requests in service order
  dram_wdata_s                 wbeat_q [$];
  logic [7:0]                  ref_mem [int];
  logic [7:0]                  dram_mem [int];
  int                          rr_ptr = 0;
  int                          rd_delay = 0;
  int                          low_run [num_cache];
  int                          cycles;
  int                          req_errs = 0;
  int                          wdata_errs = 0;
  int                          rdata_errs = 0;
  int                          yumi_errs = 0;
  int                          other_errs = 0;

  cache_to_dram_top #(.num_cache_p(num_cache), .req_queue_depth_p(16)) dut_i (
    .core_clk_i        (core_clk),
    .core_reset_i      (core_reset),
    .dma_pkt_i         (dma_pkt),
    .dma_pkt_v_i       (dma_pkt_v),
    .dma_pkt_yumi_o    (dma_pkt_yumi),
    .dma_data_o        (rd_data),
    .dma_data_v_o      (rd_v),
    .dma_data_ready_i  (rd_ready),
    .dma_data_i        (wr_data),
    .dma_data_v_i      (wr_v),
    .dma_data_yumi_o   (wr_yumi),
    .dram_req_o        (dram_req),
    .dram_req_v_o      (dram_req_v),
    .dram_req_yumi_i   (dram_req_yumi),
    .dram_wdata_o      (dram_wdata),
    .dram_wdata_v_o    (dram_wdata_v),
    .dram_wdata_yumi_i (dram_wdata_yumi),
    .dram_rdata_i      (dram_rdata),
    .dram_rdata_v_i    (dram_rdata_v)
  );

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  // untouched bytes read back as a mix of all address bits
  function automatic logic [7:0] fill_byte(input int a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h3c;
  endfunction

  function automatic logic [7:0] ref_byte(input int a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
  endfunction

  function automatic logic [7:0] dram_byte(input int a);
    return dram_mem.exists(a) ? dram_mem[a] : fill_byte(a);
  endfunction

  // index on top, block bits 15..5, beat index, 3 zero bits
  function automatic int beat_addr(input int c, input logic [cache_addr_width-1:0] a,
                                   input int k);
    return (c << (dram_addr_width - idx_w)) | (int'(a[15:5]) << 5) | (k << 3);
  endfunction

  task automatic check_req(input dram_req_s act, input dram_req_s exp);
    if (act !== exp) begin
      req_errs++;
      $display("CHECK FAILED at %0t: dram_req_o got op=%0d addr=%h, expected op=%0d addr=%h",
               $time, act.op, act.addr, exp.op, exp.addr);
    end
  endtask

  task automatic check_wdata(input dram_wdata_s act, input dram_wdata_s exp);
    if (act !== exp) begin
      wdata_errs++;
      $display("CHECK FAILED at %0t: dram_wdata_o got %h/%h, expected %h/%h",
               $time, act.data, act.mask, exp.data, exp.mask);
    end
  endtask

  task automatic check_rdata(input int c, input logic [cache_word_width-1:0] act,
                             input logic [cache_word_width-1:0] exp);
    if (act !== exp) begin
      rdata_errs++;
      $display("CHECK FAILED at %0t: dma_data_o[%0d] got %h, expected %h", $time, c, act, exp);
    end
  endtask

  task automatic check_yumi(input logic [num_cache-1:0] act, input logic [num_cache-1:0] exp);
    if (act !== exp) begin
      yumi_errs++;
      $display("CHECK FAILED at %0t: dma_pkt_yumi_o got %b, expected %b", $time, act, exp);
    end
  endtask

  // random packets for one cache and their expected traffic
  task automatic make_packets(input int c);
    dma_pkt_s                    p;
    dram_req_s                   r;
    dram_wdata_s                 b;
    logic [cache_word_width-1:0] w [block_words];
    logic [cache_word_width-1:0] word;
    int                          base;
    for (int n = 0; n < pkts_per_cache; n++) begin
      p.op = ($random(seed) & 1) ? DMA_WRITE : DMA_READ;
      p.addr = cache_addr_width'($random(seed)) & 28'h000ffff; // stays inside the bank
      p.mask = block_words'($random(seed));
      pkt_q[c].push_back(p);
      base = beat_addr(c, p.addr, 0);
      for (int k = 0; k < beats_per_block; k++) begin
        r.op = (p.op == DMA_WRITE) ? DRAM_WRITE : DRAM_READ;
        r.addr = dram_addr_width'(beat_addr(c, p.addr, k));
        exp_req[c].push_back(r);
      end
      for (int i = 0; i < block_words; i++) begin
        if (p.op == DMA_WRITE) begin
          w[i] = $random(seed);
          word_q[c].push_back(w[i]);
          for (int j = 0; j < 4; j++) begin
            if (p.mask[i]) ref_mem[base + 4*i + j] = w[i][8*j +: 8];
          end
        end else begin
          for (int j = 0; j < 4; j++) word[8*j +: 8] = ref_byte(base + 4*i + j);
          exp_rd[c].push_back(word);
        end
      end
      if (p.op == DMA_WRITE) begin
        for (int k = 0; k < beats_per_block; k++) begin
          b.data = {w[2*k+1], w[2*k]};
          b.mask = {{4{p.mask[2*k+1]}}, {4{p.mask[2*k]}}};
          exp_wdata[c].push_back(b);
        end
      end
    end
  endtask

  function automatic bit all_sent();
    for (int c = 0; c < num_cache; c++) begin
      if (pkt_q[c].size() != 0 || word_q[c].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic bit all_done();
    for (int c = 0; c < num_cache; c++) begin
      if (exp_req[c].size() != 0 || exp_wdata[c].size() != 0) return 1'b0;
      if (exp_rd[c].size() != 0) return 1'b0;
    end
    return (pend_q.size() == 0) && (wbeat_q.size() == 0);
  endfunction

  // cache models
  always @(posedge core_clk) begin
    logic [num_cache-1:0] exp_yumi;
    int                   win;
    if (run) begin
      if (dma_pkt_yumi != '0) begin
        win = -1;
        for (int i = 0; i < num_cache; i++) begin
          if (win < 0 && dma_pkt_v[(rr_ptr + i) % num_cache]) win = (rr_ptr + i) % num_cache;
        end
        exp_yumi = '0;
        if (win >= 0) begin
          exp_yumi[win] = 1'b1;
          rr_ptr = (win + 1) % num_cache; // priority moves one past the winner
        end
        check_yumi(dma_pkt_yumi, exp_yumi);
      end
      for (int c = 0; c < num_cache; c++) begin
        if (dma_pkt_yumi[c] && dma_pkt_v[c]) void'(pkt_q[c].pop_front());
        if (!dma_pkt_v[c] || dma_pkt_yumi[c]) begin
          if (pkt_q[c].size() > 0 && ($random(seed) & 3) != 0) begin
            dma_pkt[c] <= pkt_q[c][0];
            dma_pkt_v[c] <= 1'b1;
          end else begin
            dma_pkt_v[c] <= 1'b0;
          end
        end
        if (wr_yumi[c] && wr_v[c]) void'(word_q[c].pop_front());
        if (!wr_v[c] || wr_yumi[c]) begin
          if (word_q[c].size() > 0 && ($random(seed) & 3) != 0) begin
            wr_data[c] <= word_q[c][0];
            wr_v[c] <= 1'b1;
          end else begin
            wr_v[c] <= 1'b0;
          end
        end
        if (rd_v[c] && rd_ready[c]) begin
          if (exp_rd[c].size() == 0) begin
            other_errs++;
            $display("cache %0d received a read word it never asked for at %0t", c, $time);
          end else begin
            check_rdata(c, rd_data[c], exp_rd[c].pop_front());
          end
        end
        if (low_run[c] < 4 && ($random(seed) & 7) == 0) begin
          rd_ready[c] <= 1'b0;
          low_run[c]++;
        end else begin
          rd_ready[c] <= 1'b1;
          low_run[c] = 0;
        end
      end
    end
  end

  // dram model serving requests strictly in order
  always @(posedge core_clk) begin
    dram_req_s   r;
    dram_wdata_s wb;
    dram_rdata_s rb;
    int          owner;
    if (run) begin
      if (dram_req_v && dram_req_yumi) begin
        owner = int'(dram_req.addr[dram_addr_width-1 -: idx_w]);
        if (exp_req[owner].size() == 0) begin
          other_errs++;
          $display("unexpected dram request for cache %0d at %0t", owner, $time);
        end else begin
          check_req(dram_req, exp_req[owner].pop_front());
        end
        pend_q.push_back(dram_req);
      end
      if (dram_wdata_v && dram_wdata_yumi) wbeat_q.push_back(dram_wdata);
      dram_req_yumi <= ($random(seed) & 3) != 0;
      dram_wdata_yumi <= ($random(seed) & 3) != 0;
      dram_rdata_v <= 1'b0;
      if (pend_q.size() > 0) begin
        r = pend_q[0];
        if (r.op == DRAM_WRITE) begin
          if (wbeat_q.size() > 0) begin
            wb = wbeat_q.pop_front();
            void'(pend_q.pop_front());
            owner = int'(r.addr[dram_addr_width-1 -: idx_w]);
            if (exp_wdata[owner].size() == 0) begin
              other_errs++;
              $display("write beat for cache %0d has no expected data at %0t", owner, $time);
            end else begin
              check_wdata(wb, exp_wdata[owner].pop_front());
            end
            for (int i = 0; i < 8; i++) begin
              if (wb.mask[i]) dram_mem[int'(r.addr) + i] = wb.data[8*i +: 8];
            end
          end
        end else if (rd_delay == 0) begin
          rd_delay = 1 + {$random(seed)} % 5;
        end else if (rd_delay == 1) begin
          for (int i = 0; i < 8; i++) rb.data[8*i +: 8] = dram_byte(int'(r.addr) + i);
          rb.addr = r.addr;
          dram_rdata <= rb;
          dram_rdata_v <= 1'b1;
          void'(pend_q.pop_front());
          rd_delay = 0;
        end else begin
          rd_delay--;
        end
      end
    end
  end

  initial begin
    seed = 93;
    core_reset = 1'b1;
    for (int c = 0; c < num_cache; c++) begin
      low_run[c] = 0;
      make_packets(c);
    end
    repeat (2) @(posedge core_clk);
    core_reset <= 1'b0;
    run <= 1'b1;
    @(posedge core_clk);
    if (dram_req_v !== 1'b0 || dram_wdata_v !== 1'b0 || rd_v !== '0 ||
        dma_pkt_yumi !== '0 || wr_yumi !== '0) begin
      other_errs++;
      $display("a valid or yumi output is not low right after reset");
    end
    cycles = 0;
    while (!all_sent() && cycles < wait_limit) begin
      @(posedge core_clk);
      cycles++;
    end
    if (!all_sent()) begin
      other_errs++;
      $display("timeout: caches still hold packets or write words the DUT never took");
    end
    cycles = 0;
    while (!all_done() && cycles < wait_limit) begin
      @(posedge core_clk);
      cycles++;
    end
    if (!all_done()) begin
      other_errs++;
      $display("timeout: expected dram or cache traffic never completed");
    end
    repeat (20) @(posedge core_clk); // idle window to catch stray traffic
    if (pend_q.size() != 0 || wbeat_q.size() != 0 || rd_v != '0) begin
      other_errs++;
      $display("extra traffic showed up after all expected traffic completed");
    end
    $display("errors: req=%0d wdata=%0d rdata=%0d yumi=%0d other=%0d",
             req_errs, wdata_errs, rdata_errs, yumi_errs, other_errs);
    if (req_errs + wdata_errs + rdata_errs + yumi_errs + other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
cache_dma_pkg.sv
dram_chan_pkg.sv
dma_req_arbiter.sv
dram_req_splitter.sv
dram_write_packer.sv
dram_read_router.sv
cache_to_dram_top.sv
tb_cache_to_dram.sv

// ==== Makefile ====
TOP = tb_cache_to_dram

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
